//--- pulse_ctrl_pkg.sv
package pulse_ctrl_pkg;

	// ----------------------------------------------------------
	// sizes and timing
	// ----------------------------------------------------------
	localparam int NUM_CAP        = 2;    // capacitor channels
	localparam int ADC_W          = 32;   // signed adc value and setpoint
	localparam int TICK_DIV       = 50;   // sys_clk cycles per 1 us tick
	localparam int SCR_HOLD_TICKS = 50;   // scr on time in ticks
	localparam int DEBOUNCE_LAST  = 5;    // last settle count, six samples in all

	// one channel's measurement inputs
	typedef struct packed {
		logic signed [ADC_W-1:0] adc_value;
		logic signed [ADC_W-1:0] setpoint;
	} cap_sample_t;

	// ----------------------------------------------------------
	// state encodings
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_MEASURE,
		CAP_CHARGE,
		CAP_DISCHARGE
	} cap_mode_t;

	typedef enum logic {
		SCR_OFF,
		SCR_ON
	} scr_state_t;

	// ----------------------------------------------------------
	// grouped control bits
	// ----------------------------------------------------------

	// last member is bit 0, so bit order matches the gate driver board
	typedef struct packed {
		logic cap1_charge_lo;   // bit 4, low-current charge
		logic cap2_discharge;   // bit 3
		logic cap2_charge;      // bit 2
		logic cap1_discharge;   // bit 1
		logic cap1_charge_hi;   // bit 0, high-current charge
	} igbt_en_t;

	// bit n is the strobe from key n
	typedef struct packed {
		logic scr2_fire;
		logic scr1_fire;
		logic cap2_start;
		logic cap1_start;
	} key_press_t;

endpackage

//--- key_edge_detect.sv
`timescale 1ns/1ps

module key_edge_detect (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic [3:0]                 key_push,    // active low
	output pulse_ctrl_pkg::key_press_t key_press
);
	import pulse_ctrl_pkg::*;

	logic [3:0] key_sync0;
	logic [3:0] key_sync1;
	logic [3:0] key_prev;    // last synced level, for the edge

	// keys idle high, reset to the released level so no false press
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_sync0 <= 4'hf;
			key_sync1 <= 4'hf;
			key_prev  <= 4'hf;
			key_press <= '0;
		end else begin
			key_sync0 <= key_push;
			key_sync1 <= key_sync0;
			key_prev  <= key_sync1;
			// high to low on the synced key is a press
			key_press <= key_press_t'(key_prev & ~key_sync1);
		end
	end

endmodule

//--- cap_voltage_judge.sv
`timescale 1ns/1ps

module cap_voltage_judge (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        enable,     // channel in measure
	input  pulse_ctrl_pkg::cap_sample_t sample,
	output logic                        done,       // verdict strobe
	output logic                        over        // above setpoint, valid with done
);
	import pulse_ctrl_pkg::*;

	logic       side_over;    // current sample above setpoint
	logic       last_over;    // side of the previous sample
	logic [2:0] settle_cnt;   // same-side samples seen so far

	assign side_over = $signed(sample.adc_value) > $signed(sample.setpoint);

	// ----------------------------------------------------------
	// settling counter
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			settle_cnt <= '0;
			done       <= 1'b0;
			over       <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!enable) begin
				settle_cnt <= '0;
			end else if (settle_cnt == 3'd0 || side_over != last_over) begin
				settle_cnt <= 3'd1;   // first sample of a new run
			end else if (settle_cnt == DEBOUNCE_LAST) begin
				// sixth sample on the same side
				settle_cnt <= '0;
				done       <= 1'b1;
				over       <= side_over;
			end else begin
				settle_cnt <= settle_cnt + 3'd1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (enable) begin
			last_over <= side_over;
		end
	end

	a_settle_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		settle_cnt <= DEBOUNCE_LAST);

endmodule

//--- cap_mode_ctrl.sv
`timescale 1ns/1ps

module cap_mode_ctrl (
	input  logic                                                   sys_clk,
	input  logic                                                   sys_rst_n,
	input  logic [pulse_ctrl_pkg::NUM_CAP-1:0]                     cap_start,
	input  logic [pulse_ctrl_pkg::NUM_CAP-1:0]                     target_reached,
	input  logic [pulse_ctrl_pkg::NUM_CAP-1:0]                     judge_done,
	input  logic [pulse_ctrl_pkg::NUM_CAP-1:0]                     judge_over,
	output pulse_ctrl_pkg::cap_mode_t [pulse_ctrl_pkg::NUM_CAP-1:0] cap_mode
);
	import pulse_ctrl_pkg::*;

	cap_mode_t [NUM_CAP-1:0] mode_next;

	// ----------------------------------------------------------
	// next mode per channel
	// ----------------------------------------------------------
	always_comb begin
		for (int i = 0; i < NUM_CAP; i++) begin
			mode_next[i] = cap_mode[i];
			if (cap_start[i]) begin
				mode_next[i] = CAP_MEASURE;   // a press always re-measures
			end else begin
				case (cap_mode[i])
					CAP_IDLE: begin
						mode_next[i] = CAP_IDLE;
					end
					CAP_MEASURE: begin
						if (judge_done[i]) begin
							mode_next[i] = judge_over[i] ? CAP_DISCHARGE : CAP_CHARGE;
						end
					end
					CAP_CHARGE,
					CAP_DISCHARGE: begin
						// leave once the capacitor reports its target
						if (target_reached[i]) begin
							mode_next[i] = CAP_IDLE;
						end
					end
					default: begin
						mode_next[i] = CAP_IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < NUM_CAP; i++) begin
				cap_mode[i] <= CAP_IDLE;
			end
		end else begin
			cap_mode <= mode_next;
		end
	end

	// the judge only runs in measure, so a verdict outside it is a wiring fault
	for (genvar g = 0; g < NUM_CAP; g++) begin : g_chk
		a_done_in_measure: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			judge_done[g] |-> cap_mode[g] == CAP_MEASURE);
	end

endmodule

//--- igbt_gate_drive.sv
`timescale 1ns/1ps

module igbt_gate_drive (
	input  logic                                                   sys_clk,
	input  logic                                                   sys_rst_n,
	input  pulse_ctrl_pkg::cap_mode_t [pulse_ctrl_pkg::NUM_CAP-1:0] cap_mode,
	output pulse_ctrl_pkg::igbt_en_t                               igbt_en
);
	import pulse_ctrl_pkg::*;

	logic [NUM_CAP-1:0] chg_q;   // charge enable per capacitor
	logic [NUM_CAP-1:0] dis_q;   // discharge enable per capacitor

	// ----------------------------------------------------------
	// enables with break-before-make interlock
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			chg_q <= '0;
			dis_q <= '0;
		end else begin
			for (int i = 0; i < NUM_CAP; i++) begin
				case (cap_mode[i])
					CAP_IDLE: begin
						chg_q[i] <= 1'b0;
						dis_q[i] <= 1'b0;
					end
					CAP_CHARGE: begin
						dis_q[i] <= 1'b0;
						chg_q[i] <= ~dis_q[i];   // waits one cycle after discharge drops
					end
					CAP_DISCHARGE: begin
						chg_q[i] <= 1'b0;
						dis_q[i] <= ~chg_q[i];
					end
					default: begin
						// measure keeps the last verdict running
						chg_q[i] <= chg_q[i];
						dis_q[i] <= dis_q[i];
					end
				endcase
			end
		end
	end

	always_comb begin
		igbt_en.cap1_charge_hi = chg_q[0];
		igbt_en.cap1_charge_lo = chg_q[0];   // both cap1 charge paths together
		igbt_en.cap1_discharge = dis_q[0];
		igbt_en.cap2_charge    = chg_q[1];
		igbt_en.cap2_discharge = dis_q[1];
	end

	a_cap1_interlock: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!((igbt_en.cap1_charge_hi || igbt_en.cap1_charge_lo) && igbt_en.cap1_discharge));
	a_cap2_interlock: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(igbt_en.cap2_charge && igbt_en.cap2_discharge));

endmodule

//--- scr_pulse_timer.sv
`timescale 1ns/1ps

module scr_pulse_timer (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [1:0] scr_fire,   // press strobes
	output logic [1:0] scr_en
);
	import pulse_ctrl_pkg::*;

	logic [$clog2(TICK_DIV)-1:0]         div_cnt;
	logic                                tick;         // one cycle per us
	scr_state_t [1:0]                    scr_state;
	logic [$clog2(SCR_HOLD_TICKS+1)-1:0] hold_cnt [2];  // ticks since turn-on

	// ----------------------------------------------------------
	// 1 us tick
	// ----------------------------------------------------------
	assign tick = (div_cnt == TICK_DIV - 1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------
	// scr on-time per thyristor
	// ----------------------------------------------------------
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			for (int i = 0; i < 2; i++) begin
				scr_state[i] <= SCR_OFF;
				hold_cnt[i]  <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				case (scr_state[i])
					SCR_OFF: begin
						if (scr_fire[i]) begin
							scr_state[i] <= SCR_ON;
							hold_cnt[i]  <= '0;   // count from turn-on
						end
					end
					default: begin
						// fire strobes are ignored while on
						if (tick) begin
							hold_cnt[i] <= hold_cnt[i] + 1'b1;
							if (hold_cnt[i] == SCR_HOLD_TICKS - 1) begin
								scr_state[i] <= SCR_OFF;
							end
						end
					end
				endcase
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			scr_en[i] = (scr_state[i] == SCR_ON);
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_chk
		a_hold_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			hold_cnt[g] <= SCR_HOLD_TICKS);
	end

endmodule

//--- pulse_logic_gen.sv
`timescale 1ns/1ps

module pulse_logic_gen (
	input  logic                               sys_clk,
	input  logic                               sys_rst_n,
	input  pulse_ctrl_pkg::cap_sample_t        cap1_sample,
	input  pulse_ctrl_pkg::cap_sample_t        cap2_sample,
	input  logic [3:0]                         key_push,         // active low
	input  logic [pulse_ctrl_pkg::NUM_CAP-1:0] target_reached,
	output pulse_ctrl_pkg::igbt_en_t           igbt_en,
	output logic [1:0]                         scr_en
);
	import pulse_ctrl_pkg::*;

	key_press_t              key_press;
	cap_mode_t [NUM_CAP-1:0] cap_mode;
	logic [NUM_CAP-1:0]      judge_done;
	logic [NUM_CAP-1:0]      judge_over;

	// ----------------------------------------------------------
	// key front end
	// ----------------------------------------------------------
	key_edge_detect u_key_edge_detect (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_push  (key_push),
		.key_press (key_press)
	);

	// ----------------------------------------------------------
	// capacitor path
	// ----------------------------------------------------------
	cap_mode_ctrl u_cap_mode_ctrl (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.cap_start      ({key_press.cap2_start, key_press.cap1_start}),
		.target_reached (target_reached),
		.judge_done     (judge_done),
		.judge_over     (judge_over),
		.cap_mode       (cap_mode)
	);

	cap_voltage_judge u_cap1_judge (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.enable    (cap_mode[0] == CAP_MEASURE),
		.sample    (cap1_sample),
		.done      (judge_done[0]),
		.over      (judge_over[0])
	);

	cap_voltage_judge u_cap2_judge (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.enable    (cap_mode[1] == CAP_MEASURE),
		.sample    (cap2_sample),   // own channel's adc value
		.done      (judge_done[1]),
		.over      (judge_over[1])
	);

	igbt_gate_drive u_igbt_gate_drive (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cap_mode  (cap_mode),
		.igbt_en   (igbt_en)
	);

	// ----------------------------------------------------------
	// thyristor path
	// ----------------------------------------------------------
	scr_pulse_timer u_scr_pulse_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scr_fire  ({key_press.scr2_fire, key_press.scr1_fire}),
		.scr_en    (scr_en)
	);

endmodule

//--- tb_pulse_logic_gen.sv
`timescale 1ns/1ps

module tb_pulse_logic_gen;
	import pulse_ctrl_pkg::*;

	// six short tests plus two full scr pulses, with wide margin
	localparam int WATCHDOG_CYCLES = 12 * TICK_DIV * SCR_HOLD_TICKS;

	logic        sys_clk;
	logic        sys_rst_n;
	cap_sample_t cap1_sample;
	cap_sample_t cap2_sample;
	logic [3:0]  key_push;
	logic [1:0]  target_reached;
	igbt_en_t    igbt_en;
	logic [1:0]  scr_en;

	logic [31:0] lcg_state = 32'hcf39;
	int          err_cnt = 0;
	int          lock_err_cnt = 0;   // counted by the compare process
	int          test_cnt = 0;
	int          test_ok_cnt = 0;

	pulse_logic_gen u_pulse_logic_gen (
		.sys_clk        (sys_clk),
		.sys_rst_n      (sys_rst_n),
		.cap1_sample    (cap1_sample),
		.cap2_sample    (cap2_sample),
		.key_push       (key_push),
		.target_reached (target_reached),
		.igbt_en        (igbt_en),
		.scr_en         (scr_en)
	);

	always #50 sys_clk = ~sys_clk;

	// ------------------------------------------------------------
	// stimulus and reference models
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic cap_sample_t rand_sample();
		cap_sample_t s;
		s.adc_value = lcg_next();
		s.setpoint  = lcg_next();
		return s;
	endfunction

	// at or below setpoint charges
	function automatic cap_mode_t ref_cap_mode(cap_sample_t s);
		if (s.adc_value <= s.setpoint) begin
			return CAP_CHARGE;
		end
		return CAP_DISCHARGE;
	endfunction

	// enables for one active channel with the other one idle
	function automatic igbt_en_t expected_igbt(int ch, cap_mode_t mode);
		igbt_en_t e;
		e = '0;
		if (ch == 0) begin
			e.cap1_charge_hi = (mode == CAP_CHARGE);
			e.cap1_charge_lo = (mode == CAP_CHARGE);
			e.cap1_discharge = (mode == CAP_DISCHARGE);
		end else begin
			e.cap2_charge    = (mode == CAP_CHARGE);
			e.cap2_discharge = (mode == CAP_DISCHARGE);
		end
		return e;
	endfunction

	// first tick may land anywhere inside one divider period
	function automatic void ref_scr_window(output int min_w, output int max_w);
		min_w = (SCR_HOLD_TICKS - 1) * TICK_DIV;
		max_w = SCR_HOLD_TICKS * TICK_DIV;
	endfunction

	task press_key(input int idx);
		@(posedge sys_clk);
		key_push[idx] <= 1'b0;
		repeat (3) @(posedge sys_clk);
		key_push[idx] <= 1'b1;
	endtask

	// poll on the falling edge until igbt_en matches
	task wait_igbt(input igbt_en_t exp, input int max_cycles);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (igbt_en !== exp && n < max_cycles) begin
			@(negedge sys_clk);
			n++;
		end
		if (igbt_en !== exp) begin
			$display("Fail igbt_en expected %h got %h", exp, igbt_en);
			err_cnt++;
		end
	endtask

	task release_target(input int ch);
		@(posedge sys_clk);
		target_reached[ch] <= 1'b1;
		wait_igbt('0, 3);
		@(posedge sys_clk);
		target_reached[ch] <= 1'b0;
	endtask

	task run_verdict(input int ch);
		cap_sample_t smp;
		smp = rand_sample();
		@(posedge sys_clk);
		if (ch == 0) cap1_sample <= smp;
		else         cap2_sample <= smp;
		press_key(ch);
		wait_igbt(expected_igbt(ch, ref_cap_mode(smp)), 17);   // 20 from the press
		release_target(ch);
	endtask

	task measure_scr(input int idx, input bit refire);
		int min_w;
		int max_w;
		int width;
		int n;
		ref_scr_window(min_w, max_w);
		press_key(idx + 2);
		n = 0;
		@(negedge sys_clk);
		while (!scr_en[idx] && n < 10) begin
			@(negedge sys_clk);
			n++;
		end
		if (!scr_en[idx]) begin
			$display("scr %0d enable never rose after its key press", idx + 1);
			err_cnt++;
		end else begin
			width = 0;
			while (scr_en[idx] && width <= max_w + 10) begin
				@(posedge sys_clk);
				if (refire && width == 500) key_push[idx + 2] <= 1'b0;   // press again while on
				if (refire && width == 504) key_push[idx + 2] <= 1'b1;
				@(negedge sys_clk);
				width++;
			end
			if (width < min_w || width > max_w) begin
				$display("Fail scr_en[%0d] width expected %h..%h got %h",
					idx, min_w, max_w, width);
				err_cnt++;
			end
		end
	endtask

	task finish_test(input string name, input int mark);
		test_cnt++;
		if (err_cnt + lock_err_cnt == mark) begin
			test_ok_cnt++;
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: not ok", test_cnt, name);
		end
	endtask

	// ------------------------------------------------------------
	// interlock compare, every cycle
	// ------------------------------------------------------------
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if ((igbt_en.cap1_charge_hi || igbt_en.cap1_charge_lo) && igbt_en.cap1_discharge) begin
				$display("Fail igbt_en cap1 charge and discharge together %h", igbt_en);
				lock_err_cnt++;
			end
			if (igbt_en.cap2_charge && igbt_en.cap2_discharge) begin
				$display("Fail igbt_en cap2 charge and discharge together %h", igbt_en);
				lock_err_cnt++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		cap_sample_t smp;
		int mark;
		sys_clk        = 1'b0;
		sys_rst_n      = 1'b0;
		cap1_sample    = '0;
		cap2_sample    = '0;
		key_push       = 4'hf;   // keys released
		target_reached = '0;
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		mark = err_cnt + lock_err_cnt;
		for (int k = 0; k < 100; k++) begin
			@(negedge sys_clk);
			if (igbt_en !== '0 || scr_en !== '0) begin
				$display("Fail idle outputs igbt_en %h scr_en %h, expected 00", igbt_en, scr_en);
				err_cnt++;
				break;
			end
		end
		finish_test("idle after reset", mark);

		mark = err_cnt + lock_err_cnt;
		run_verdict(0);
		finish_test("channel 1 verdict", mark);

		mark = err_cnt + lock_err_cnt;
		run_verdict(1);
		finish_test("channel 2 verdict", mark);

		// charge first, then a re-measure above setpoint
		mark = err_cnt + lock_err_cnt;
		smp = rand_sample();
		smp.setpoint  = smp.setpoint >>> 2;
		smp.adc_value = smp.setpoint - 500;
		@(posedge sys_clk);
		cap1_sample <= smp;
		press_key(0);
		wait_igbt(expected_igbt(0, ref_cap_mode(smp)), 17);
		smp.adc_value = smp.setpoint + 500;
		@(posedge sys_clk);
		cap1_sample <= smp;
		press_key(0);
		wait_igbt(expected_igbt(0, ref_cap_mode(smp)), 17);
		release_target(0);
		finish_test("re-measure", mark);

		mark = err_cnt + lock_err_cnt;
		smp = rand_sample();
		smp.setpoint = smp.setpoint >>> 2;
		for (int k = 0; k < 60; k++) begin
			@(posedge sys_clk);
			if (k == 0) key_push[1] <= 1'b0;
			if (k == 3) key_push[1] <= 1'b1;
			if (k % 3 == 0) begin
				cap2_sample.setpoint  <= smp.setpoint;
				cap2_sample.adc_value <= ((k / 3) % 2 == 0) ? smp.setpoint + 1000
				                                             : smp.setpoint - 1000;
			end
			@(negedge sys_clk);
			if (igbt_en.cap2_charge || igbt_en.cap2_discharge) begin
				$display("Fail igbt_en while flipping expected 00 got %h", igbt_en);
				err_cnt++;
			end
		end
		smp = rand_sample();
		@(posedge sys_clk);
		cap2_sample <= smp;
		wait_igbt(expected_igbt(1, ref_cap_mode(smp)), 20);
		release_target(1);
		finish_test("debounce", mark);

		mark = err_cnt + lock_err_cnt;
		measure_scr(0, 1'b1);
		measure_scr(1, 1'b0);
		finish_test("scr pulses", mark);

		$display("%0d of %0d tests ok, %0d check errors, %0d interlock errors",
			test_ok_cnt, test_cnt, err_cnt, lock_err_cnt);
		if (err_cnt == 0 && lock_err_cnt == 0 && test_ok_cnt == test_cnt) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- pulse_logic_gen.f
pulse_ctrl_pkg.sv
key_edge_detect.sv
cap_voltage_judge.sv
cap_mode_ctrl.sv
igbt_gate_drive.sv
scr_pulse_timer.sv
pulse_logic_gen.sv
tb_pulse_logic_gen.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pulse_logic_gen \
	-f pulse_logic_gen.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation error" >> sim.log
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
